//--- hw/dfd_cmd_decode.sv
// ----------------------------------------------------------
// Command decode: arm FSM, event mask register and
// one-cycle clear pulse from the command strobe
// ----------------------------------------------------------
`timescale 1ns/1ns

module dfd_cmd_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_valid,  // One-cycle command strobe
    input  dfd_event_pkg::cmd_op_e  cmd_op,     // Opcode, valid with strobe
    input  dfd_event_pkg::ev_vec_t  cmd_arg,    // Mask value for CMD_SET_MASK
    output logic                    armed,      // Capture enable level
    output dfd_event_pkg::ev_vec_t  ev_mask,    // 1 enables a line
    output logic                    clear       // One-cycle clear pulse
);
    import dfd_event_pkg::*;

    arm_state_e state_q;  // Arm FSM state
    arm_state_e state_d;

    // Next state, only ARM and DISARM move the FSM
    always_comb begin
        state_d = state_q;
        if (cmd_valid) begin
            case (cmd_op)
                CMD_ARM:    state_d = ST_ARMED;
                CMD_DISARM: state_d = ST_IDLE;
                default:    state_d = state_q;  // Nop, mask, clear and unused codes
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            ev_mask <= '0;     // All lines masked after reset
            clear   <= 1'b0;
        end else begin
            state_q <= state_d;
            clear   <= cmd_valid && (cmd_op == CMD_CLEAR);  // Self-clearing next cycle
            if (cmd_valid && (cmd_op == CMD_SET_MASK)) begin
                ev_mask <= cmd_arg;
            end
        end
    end

    assign armed = (state_q == ST_ARMED);

endmodule

//--- hw/dfd_event_log.sv
// ----------------------------------------------------------
// Event log: capture record register and saturating
// capture and overflow counters
// ----------------------------------------------------------
`timescale 1ns/1ns

module dfd_event_log (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,       // Zeroes both counters
    input  logic                    sel_fire,
    input  dfd_event_pkg::ev_idx_t  sel_idx,
    input  dfd_event_pkg::ev_tag_t  sel_tag,
    input  dfd_event_pkg::ev_vec_t  sel_onehot,
    input  dfd_event_pkg::ev_vec_t  sel_therm,
    input  logic                    sel_ovf,
    output logic                    cap_valid,   // One-cycle pulse per capture
    output dfd_event_pkg::ev_idx_t  cap_idx,     // Held until next capture
    output dfd_event_pkg::ev_tag_t  cap_tag,
    output dfd_event_pkg::ev_vec_t  cap_onehot,
    output dfd_event_pkg::ev_vec_t  cap_therm,
    output dfd_event_pkg::ev_cnt_t  cap_count,   // Captures since clear
    output dfd_event_pkg::ev_cnt_t  ovf_count    // Overflow cycles since clear
);
    import dfd_event_pkg::*;

    localparam ev_cnt_t CNT_MAX = '1;  // Saturation point

    // Capture record, loaded only on a pick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid  <= 1'b0;
            cap_idx    <= '0;
            cap_tag    <= '0;
            cap_onehot <= '0;
            cap_therm  <= '0;
        end else begin
            cap_valid <= sel_fire;
            if (sel_fire) begin
                cap_idx    <= sel_idx;
                cap_tag    <= sel_tag;
                cap_onehot <= sel_onehot;
                cap_therm  <= sel_therm;
            end
        end
    end

    // Counters, clear has priority over increments
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_count <= '0;
            ovf_count <= '0;
        end else if (clear) begin
            cap_count <= '0;
            ovf_count <= '0;
        end else begin
            if (sel_fire && (cap_count != CNT_MAX)) cap_count <= cap_count + 1'b1;
            if (sel_ovf && (ovf_count != CNT_MAX)) ovf_count <= ovf_count + 1'b1;
        end
    end

endmodule

//--- hw/dfd_event_params.svh
// ----------------------------------------------------------
// Size and scan-order macros for the event capture unit
// ----------------------------------------------------------
`ifndef DFD_EVENT_PARAMS_SVH
`define DFD_EVENT_PARAMS_SVH

// Number of event lines
`define DFD_EV_NUM      8
// Binary index width, log2 of the line count
`define DFD_EV_IDX_W    3
// Tag carried by each event pulse
`define DFD_EV_TAG_W    4
// Capture and overflow counter width
`define DFD_EV_CNT_W    8
// Scan order, 1 = lowest index has priority
`define DFD_EV_DIR_L2H  1

`endif

//--- hw/dfd_event_pkg.sv
// ----------------------------------------------------------
// Shared types for the event capture unit
// Command opcodes, arm states, vector/index/tag/counter
// ----------------------------------------------------------
`include "dfd_event_params.svh"

package dfd_event_pkg;

    typedef logic [`DFD_EV_NUM-1:0]   ev_vec_t;  // One bit per event line
    typedef logic [`DFD_EV_IDX_W-1:0] ev_idx_t;  // Event line number
    typedef logic [`DFD_EV_TAG_W-1:0] ev_tag_t;  // Per-event tag
    typedef logic [`DFD_EV_CNT_W-1:0] ev_cnt_t;  // Saturating counter

    // Command port opcodes
    typedef enum logic [2:0] {
        CMD_NOP      = 3'd0,  // No effect
        CMD_ARM      = 3'd1,  // Start capturing
        CMD_DISARM   = 3'd2,  // Stop capturing, pending bits kept
        CMD_SET_MASK = 3'd3,  // Load mask from cmd_arg
        CMD_CLEAR    = 3'd4   // Drop pending events, zero counters
    } cmd_op_e;

    // Arm FSM states
    typedef enum logic {
        ST_IDLE  = 1'b0,  // Events collect as pending only
        ST_ARMED = 1'b1   // One capture per cycle allowed
    } arm_state_e;

endpackage

//--- hw/dfd_event_select.sv
// ----------------------------------------------------------
// Event select: sticky pending bits, tag store, overflow
// detect and priority pick of the next capture
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "dfd_event_params.svh"

module dfd_event_select (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  dfd_event_pkg::ev_vec_t                   ev_req,      // Event pulses
    input  dfd_event_pkg::ev_tag_t [`DFD_EV_NUM-1:0] ev_tag,      // Tag per line
    input  logic                                     armed,       // From decode
    input  dfd_event_pkg::ev_vec_t                   ev_mask,     // From decode
    input  logic                                     clear,       // From decode
    output logic                                     sel_fire,    // Winner this cycle
    output dfd_event_pkg::ev_idx_t                   sel_idx,     // Winner line
    output dfd_event_pkg::ev_tag_t                   sel_tag,     // Winner stored tag
    output dfd_event_pkg::ev_vec_t                   sel_onehot,  // Winner one-hot
    output dfd_event_pkg::ev_vec_t                   sel_therm,   // Winner upward
    output logic                                     sel_ovf      // Repeat hit pulse
);
    import dfd_event_pkg::*;

    ev_vec_t                   pending_q;   // Sticky pending bits
    ev_tag_t [`DFD_EV_NUM-1:0] tag_q;       // Tag latched on set
    ev_vec_t                   enc_req;     // Eligible lines
    ev_vec_t                   repeat_hit;  // Request on a line still pending
    ev_vec_t                   tag_load;    // Lines whose tag is taken this edge
    logic                      ovf_q;

    // No pick while disarmed or clearing
    assign enc_req    = pending_q & ev_mask & {`DFD_EV_NUM{armed & ~clear}};
    assign sel_fire   = |enc_req;
    assign repeat_hit = ev_req & pending_q & ~sel_onehot;  // Retiring line re-sets freely
    assign tag_load   = ev_req & (~pending_q | sel_onehot | {`DFD_EV_NUM{clear}});
    assign sel_ovf    = ovf_q;

    dfd_generic_ffs_fast #(
        .DIR_L2H    (`DFD_EV_DIR_L2H),
        .WIDTH      (`DFD_EV_NUM),
        .DATA_WIDTH (`DFD_EV_TAG_W),
        .SIZE       (`DFD_EV_IDX_W)
    ) dfd_generic_ffs_fast_inst (
        .req_in        (enc_req),
        .data_in       (tag_q),
        .data_out      (sel_tag),
        .req_out       (sel_onehot),  // Zero when nothing fires, doubles as retire
        .req_out_therm (sel_therm),
        .enc_req_out   (sel_idx)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= '0;
            ovf_q     <= 1'b0;
        end else begin
            if (clear) begin
                pending_q <= ev_req;  // Old events dropped, same-cycle pulses kept
            end else begin
                pending_q <= (pending_q & ~sel_onehot) | ev_req;
            end
            ovf_q <= ~clear & (|repeat_hit);  // One pulse per cycle however many lines
        end
    end

    // First tag of a pending event is kept, repeats do not overwrite it
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DFD_EV_NUM; i++) begin
            if (tag_load[i]) begin
                tag_q[i] <= ev_tag[i];
            end
        end
    end

endmodule

//--- hw/dfd_event_top.sv
// ----------------------------------------------------------
// Event capture unit top: decode, select and log stages
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "dfd_event_params.svh"

module dfd_event_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  dfd_event_pkg::ev_vec_t                   ev_req,     // Event pulses
    input  dfd_event_pkg::ev_tag_t [`DFD_EV_NUM-1:0] ev_tag,     // Tags, with pulses
    input  logic                                     cmd_valid,  // Command strobe
    input  dfd_event_pkg::cmd_op_e                   cmd_op,
    input  dfd_event_pkg::ev_vec_t                   cmd_arg,
    output logic                                     cap_valid,
    output dfd_event_pkg::ev_idx_t                   cap_idx,
    output dfd_event_pkg::ev_tag_t                   cap_tag,
    output dfd_event_pkg::ev_vec_t                   cap_onehot,
    output dfd_event_pkg::ev_vec_t                   cap_therm,
    output dfd_event_pkg::ev_cnt_t                   cap_count,
    output dfd_event_pkg::ev_cnt_t                   ovf_count
);
    import dfd_event_pkg::*;

    logic    armed;       // Decode to select
    ev_vec_t ev_mask;
    logic    clear;       // Decode to select and log
    logic    sel_fire;    // Select to log
    ev_idx_t sel_idx;
    ev_tag_t sel_tag;
    ev_vec_t sel_onehot;
    ev_vec_t sel_therm;
    logic    sel_ovf;

    dfd_cmd_decode dfd_cmd_decode_inst (
        .clk, .rst_n, .cmd_valid, .cmd_op, .cmd_arg,
        .armed, .ev_mask, .clear
    );

    dfd_event_select dfd_event_select_inst (
        .clk, .rst_n, .ev_req, .ev_tag, .armed, .ev_mask, .clear,
        .sel_fire, .sel_idx, .sel_tag, .sel_onehot, .sel_therm, .sel_ovf
    );

    dfd_event_log dfd_event_log_inst (
        .clk, .rst_n, .clear,
        .sel_fire, .sel_idx, .sel_tag, .sel_onehot, .sel_therm, .sel_ovf,
        .cap_valid, .cap_idx, .cap_tag, .cap_onehot, .cap_therm,
        .cap_count, .ovf_count
    );

endmodule

//--- hw/dfd_generic_ffs_fast.sv
// ----------------------------------------------------------
// Find-first-set priority encoder, combinational
// One-hot, thermometer, binary index and data outputs
// ----------------------------------------------------------
`timescale 1ns/1ns

module dfd_generic_ffs_fast #(
    parameter int DIR_L2H    = 1,              // 1 = LSB wins, 0 = MSB wins
    parameter int WIDTH      = 8,              // Request count
    parameter int DATA_WIDTH = 4,              // Payload bits per request
    parameter int SIZE       = $clog2(WIDTH)   // Encoded index width
) (
    input  logic [WIDTH-1:0]                 req_in,         // Raw requests
    input  logic [WIDTH-1:0][DATA_WIDTH-1:0] data_in,        // Payload per request
    output logic [DATA_WIDTH-1:0]            data_out,       // Winner payload
    output logic [WIDTH-1:0]                 req_out,        // Winner one-hot
    output logic [WIDTH-1:0]                 req_out_therm,  // Winner through scan end
    output logic [SIZE-1:0]                  enc_req_out     // Winner index
);

    // Maps scan step to bit position for the chosen direction
    function automatic int scan_pos(input int step);
        return (DIR_L2H != 0) ? step : (WIDTH - 1 - step);
    endfunction

    always_comb begin : scan
        logic seen;  // A request was met earlier in the scan
        int   pos;   // Bit position of the current step

        seen          = 1'b0;
        pos           = 0;
        data_out      = '0;  // Zero payload when nothing requests
        req_out       = '0;
        req_out_therm = '0;
        enc_req_out   = '0;

        for (int k = 0; k < WIDTH; k++) begin
            pos = scan_pos(k);
            if (req_in[pos] && !seen) begin    // First hit in scan order
                req_out[pos] = 1'b1;
                data_out     = data_in[pos];
                enc_req_out  = SIZE'(pos);
            end
            seen               = seen | req_in[pos];
            req_out_therm[pos] = seen;          // Stays set once the winner is passed
        end
    end

endmodule

//--- src.f
+incdir+hw
hw/dfd_event_pkg.sv
hw/dfd_generic_ffs_fast.sv
hw/dfd_cmd_decode.sv
hw/dfd_event_select.sv
hw/dfd_event_log.sv
hw/dfd_event_top.sv
testbench/dfd_event_assertions.sv
testbench/dfd_event_tb.sv

//--- testbench/dfd_event_assertions.sv
// ----------------------------------------------------------
// Concurrent checks on the capture outputs, bound to the top
// ----------------------------------------------------------
`timescale 1ns/1ns

module dfd_event_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   cap_valid,
    input dfd_event_pkg::ev_vec_t cap_onehot,
    input dfd_event_pkg::ev_vec_t cap_therm
);
    onehot_ok: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cap_onehot))
        else $error("cap_onehot has more than one bit set");
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !cap_valid)
        else $error("cap_valid high during reset");
    // Thermometer starts at the winner and runs to the scan end
    therm_ok: assert property (@(posedge clk) disable iff (!rst_n)
        cap_valid |-> (cap_onehot != '0) && ((cap_therm & cap_onehot) == cap_onehot))
        else $error("cap_therm does not cover cap_onehot");
endmodule

bind dfd_event_top dfd_event_assertions dfd_event_assertions_inst (
    .clk, .rst_n, .cap_valid, .cap_onehot, .cap_therm
);

//--- testbench/dfd_event_tb.sv
// ----------------------------------------------------------
// Directed testbench for the event capture unit
// Reference model, typed compare tasks, timeout, summary
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "dfd_event_params.svh"

module dfd_event_tb;
    import dfd_event_pkg::*;

    localparam int CYCLE_LIMIT = 400;  // Whole run takes about 120 cycles
    localparam int CAP_WAIT    = 20;   // Longest wait for one capture

    logic                      clk = 1'b0;
    logic                      rst_n;
    ev_vec_t                   ev_req;
    ev_tag_t [`DFD_EV_NUM-1:0] ev_tag;
    logic                      cmd_valid;
    cmd_op_e                   cmd_op;
    ev_vec_t                   cmd_arg;
    logic                      cap_valid;
    ev_idx_t                   cap_idx;
    ev_tag_t                   cap_tag;
    ev_vec_t                   cap_onehot;
    ev_vec_t                   cap_therm;
    ev_cnt_t                   cap_count;
    ev_cnt_t                   ovf_count;

    ev_vec_t     pend_m;                // Model pending bits
    ev_tag_t     tag_m [`DFD_EV_NUM];   // Model stored tags
    ev_vec_t     mask_m;
    logic        armed_m;
    ev_cnt_t     cnt_m;                 // Expected cap_count
    ev_cnt_t     ovf_m;                 // Expected ovf_count
    logic [31:0] lfsr_q = 32'h33ef;
    int          errors = 0;
    int          tests  = 0;
    int          failed = 0;
    int          cycles = 0;

    dfd_event_top dfd_event_top_inst (.*);

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};  // One step per bit
        end
    endtask

    task automatic check_idx(input string name, input ev_idx_t got, input ev_idx_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input ev_tag_t got, input ev_tag_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_vec(input string name, input ev_vec_t got, input ev_vec_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cnt(input string name, input ev_cnt_t got, input ev_cnt_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Command strobe for one cycle, model follows on the sampling edge
    task automatic do_cmd(input cmd_op_e op, input ev_vec_t arg);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_arg   <= arg;
        @(posedge clk);
        cmd_valid <= 1'b0;
        case (op)
            CMD_ARM:      armed_m = 1'b1;
            CMD_DISARM:   armed_m = 1'b0;
            CMD_SET_MASK: mask_m  = arg;
            CMD_CLEAR: begin
                pend_m = '0;  // Pending events and counts dropped
                cnt_m  = '0;
                ovf_m  = '0;
            end
            default: ;
        endcase
    endtask

    // One-cycle pulse on the lines in vec, random tag per line
    task automatic pulse_events(input ev_vec_t vec);
        logic [31:0]               r;
        ev_tag_t [`DFD_EV_NUM-1:0] tags;
        tags = '0;
        if ((|(vec & pend_m)) && (ovf_m != '1)) ovf_m++;  // One count per cycle
        for (int i = 0; i < `DFD_EV_NUM; i++) begin
            if (vec[i]) begin
                take_bits(`DFD_EV_TAG_W, r);
                tags[i] = r[`DFD_EV_TAG_W-1:0];
                if (!pend_m[i]) tag_m[i] = tags[i];  // First tag kept
            end
        end
        pend_m = pend_m | vec;
        @(posedge clk);
        ev_req <= vec;
        ev_tag <= tags;
        @(posedge clk);
        ev_req <= '0;
    endtask

    // Waits for the next capture, exp_wait 0 skips the latency check
    task automatic expect_capture(input int exp_wait);
        int      waited;
        ev_vec_t elig;
        ev_idx_t idx;
        ev_vec_t therm;
        elig = armed_m ? (pend_m & mask_m) : '0;
        idx  = '0;
        for (int i = `DFD_EV_NUM - 1; i >= 0; i--) begin
            if (elig[i]) idx = ev_idx_t'(i);  // Lowest enabled index wins
        end
        therm  = '1;
        therm  = therm << idx;                 // Ones from the winner upward
        waited = 1;
        @(negedge clk);
        while (!cap_valid && (waited < CAP_WAIT)) begin
            @(negedge clk);
            waited++;
        end
        if ((elig == '0) || !cap_valid) begin
            $display("Expected capture did not arrive within %0d cycles", CAP_WAIT);
            errors++;
        end else begin
            if ((exp_wait != 0) && (waited != exp_wait)) begin
                $display("Capture of line %0d came after %0d cycles, not %0d",
                         idx, waited, exp_wait);
                errors++;
            end
            pend_m[idx] = 1'b0;
            if (cnt_m != '1) cnt_m++;
            check_idx("cap_idx", cap_idx, idx);
            check_tag("cap_tag", cap_tag, tag_m[idx]);
            check_vec("cap_onehot", cap_onehot, ev_vec_t'(1) << idx);
            check_vec("cap_therm", cap_therm, therm);
            check_cnt("cap_count", cap_count, cnt_m);
        end
    endtask

    task automatic check_no_capture(input int n);
        repeat (n) begin
            @(negedge clk);
            if (cap_valid) begin
                $display("Unexpected capture of line %0d", cap_idx);
                errors++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors > err_before) begin
            failed++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        repeat (4) begin
            @(negedge clk);
            if (cap_valid !== 1'b0) begin
                $display("cap_valid is not low during reset");
                errors++;
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_cnt("cap_count", cap_count, '0);
        check_cnt("ovf_count", ovf_count, '0);
        pulse_events(8'h04);  // Disarmed and masked, stays pending
        check_no_capture(8);
        do_cmd(CMD_CLEAR, '0);
        finish_test("reset", e);
    endtask

    task automatic test_single();
        int e;
        e = errors;
        do_cmd(CMD_SET_MASK, '1);
        do_cmd(CMD_ARM, '0);
        pulse_events(8'h20);
        expect_capture(2);  // Event edge to cap_valid
        finish_test("single event", e);
    endtask

    task automatic test_burst();
        int          e;
        logic [31:0] r;
        ev_vec_t     vec;
        e = errors;
        take_bits(`DFD_EV_NUM, r);
        vec = ev_vec_t'(r) | 8'h11;  // At least two lines
        pulse_events(vec);
        for (int k = 0; k < $countones(vec); k++) begin
            expect_capture((k == 0) ? 2 : 1);  // Back to back after the first
        end
        finish_test("simultaneous events", e);
    endtask

    task automatic test_mask_disarm();
        int e;
        e = errors;
        do_cmd(CMD_SET_MASK, 8'h0f);
        pulse_events(8'h42);
        expect_capture(2);      // Line 1 only, line 6 masked
        check_no_capture(6);
        do_cmd(CMD_DISARM, '0);
        pulse_events(8'h04);
        do_cmd(CMD_SET_MASK, '1);
        check_no_capture(6);    // Enabled but disarmed
        do_cmd(CMD_ARM, '0);
        expect_capture(2);
        expect_capture(1);
        finish_test("mask and disarm", e);
    endtask

    task automatic test_overflow();
        int e;
        e = errors;
        do_cmd(CMD_SET_MASK, 8'h7f);
        pulse_events(8'h80);
        repeat (3) pulse_events(8'h80);  // Each repeat hits a pending bit
        check_no_capture(3);
        check_cnt("ovf_count", ovf_count, ovf_m);
        check_cnt("cap_count", cap_count, cnt_m);
        do_cmd(CMD_SET_MASK, '1);
        expect_capture(2);      // Tag from the first pulse, not the repeats
        finish_test("overflow", e);
    endtask

    task automatic test_clear();
        int e;
        e = errors;
        do_cmd(CMD_DISARM, '0);
        pulse_events(8'h09);
        do_cmd(CMD_CLEAR, '0);
        check_no_capture(2);
        check_cnt("cap_count", cap_count, '0);
        check_cnt("ovf_count", ovf_count, '0);
        do_cmd(CMD_SET_MASK, '1);
        do_cmd(CMD_ARM, '0);
        check_no_capture(6);    // Lines 0 and 3 were dropped
        pulse_events(8'h10);
        expect_capture(2);
        finish_test("clear", e);
    endtask

    initial begin
        rst_n     = 1'b1;
        ev_req    = '0;
        ev_tag    = '0;
        cmd_valid = 1'b0;
        cmd_op    = CMD_NOP;
        cmd_arg   = '0;
        pend_m    = '0;
        mask_m    = '0;
        armed_m   = 1'b0;
        cnt_m     = '0;
        ovf_m     = '0;
        #1 rst_n  = 1'b0;       // Falling edge starts the async reset
        test_reset();
        test_single();
        test_burst();
        test_mask_disarm();
        test_overflow();
        test_clear();
        $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
